//--- cache/cache_array.sv
// Direct-mapped cache storage
// 256 lines of tag, valid, dirty and four data words. Reads are
// combinational. Compare mode writes only on a hit and marks the line
// dirty; fill mode loads a word, sets the tag and leaves the line clean.
`timescale 1ns/1ps

module cache_array
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cache_cmd_t cmd,
    output cache_rsp_t rsp
);

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    logic [TAG_W-1:0]     tag_q  [NUM_LINES];
    logic [DATA_W-1:0]    data_q [NUM_LINES][BEATS];

    logic hit;
    logic comp_wr;
    logic fill_wr;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////
    assign hit = valid_q[cmd.index] && (tag_q[cmd.index] == cmd.tag);

    assign rsp.hit   = hit;
    assign rsp.valid = valid_q[cmd.index];
    assign rsp.dirty = dirty_q[cmd.index];
    assign rsp.tag   = tag_q[cmd.index];
    assign rsp.rdata = data_q[cmd.index][cmd.word];

    assign comp_wr = cmd.write & cmd.comp & hit;
    assign fill_wr = cmd.write & ~cmd.comp;

    //////////////////////////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_wr) begin
            valid_q[cmd.index] <= cmd.set_valid;
            dirty_q[cmd.index] <= 1'b0;
        end else if (comp_wr) begin
            dirty_q[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (comp_wr || fill_wr) begin
            data_q[cmd.index][cmd.word] <= cmd.wdata;
        end
        if (fill_wr) begin
            tag_q[cmd.index] <= cmd.tag;
        end
    end

endmodule

//--- common/mem_pkg.sv
// Data memory subsystem shared definitions
// Address split, block timing, cache and memory link structs and the
// controller state encoding used across the cache, controller and memory
package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 16;
    localparam int TAG_W   = 5;   // addr[15:11]
    localparam int INDEX_W = 8;   // addr[10:3]
    localparam int WORD_W  = 2;   // addr[2:1], addr[0] must be zero

    // Word address into main memory
    localparam int WADDR_W   = ADDR_W - 1;
    localparam int NUM_LINES = 2 ** INDEX_W;

    //////////////////////////////////////////////////////////////////////
    // Timing
    //////////////////////////////////////////////////////////////////////
    localparam int BEATS       = 4;
    localparam int MEM_LATENCY = 2;
    localparam int BANK_BUSY   = 4;

    localparam int MEM_WORDS = 2 ** WADDR_W;
    localparam int BANK_ROWS = MEM_WORDS / BEATS;

    //////////////////////////////////////////////////////////////////////
    // Link types
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [WORD_W-1:0]  word;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  wdata;
        logic               write;
        logic               comp;
        logic               set_valid;
    } cache_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] rdata;
    } cache_rsp_t;

    typedef struct packed {
        logic [WADDR_W-1:0] waddr;
        logic [DATA_W-1:0]  wdata;
        logic               wr;
        logic               rd;
    } bank_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              rd_valid;
    } bank_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        WB,
        FETCH,
        FILL,
        TOUCH,
        DONE,
        ERR
    } ctrl_state_e;

endpackage

//--- mem_system/beat_counter.sv
// Block beat counter
// Wrapping count of the words in one block. Clear wins over step and
// last flags the final beat.
`timescale 1ns/1ps

module beat_counter
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr,
    input  logic              step,
    output logic [WORD_W-1:0] count,
    output logic              last
);

    logic [WORD_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clr) begin
            count_q <= '0;
        end else if (step) begin
            // Wraps back to zero after the last beat
            count_q <= count_q + 1'b1;
        end
    end

    assign count = count_q;
    assign last  = (count_q == WORD_W'(BEATS - 1));

endmodule

//--- mem_system/cache_ctrl.sv
// Cache controller FSM
// Answers hits in the request cycle. On a miss it writes back a dirty
// victim, fetches the block one word per cycle, fills the cache and
// replays the access. Bad requests lock it in a sticky error state.
`timescale 1ns/1ps

module cache_ctrl
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] data_in,
    input  logic              rd,
    input  logic              wr,
    output cache_cmd_t        cache_cmd,
    input  cache_rsp_t        cache_rsp,
    output bank_req_t         bank_req,
    input  bank_rsp_t         bank_rsp,
    output logic              issue_clr,
    output logic              issue_step,
    output logic              fill_clr,
    output logic              fill_step,
    input  logic [WORD_W-1:0] issue_count,
    input  logic [WORD_W-1:0] fill_count,
    input  logic              issue_last,
    input  logic              fill_last,
    output logic [DATA_W-1:0] data_out,
    output logic              done,
    output logic              stall,
    output logic              cache_hit,
    output logic              err
);

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    logic [TAG_W-1:0]   addr_tag;
    logic [INDEX_W-1:0] addr_index;
    logic [WORD_W-1:0]  addr_word;
    logic               req;
    logic               bad_req;
    logic               hit_now;

    assign addr_tag   = addr[ADDR_W-1 -: TAG_W];
    assign addr_index = addr[WORD_W+1 +: INDEX_W];
    assign addr_word  = addr[1 +: WORD_W];

    assign req     = rd | wr;
    assign bad_req = addr[0] | (rd & wr);
    assign hit_now = req & ~bad_req & cache_rsp.hit;

    // Every returned word is part of a fill
    assign fill_step = bank_rsp.rd_valid;
    assign data_out  = cache_rsp.rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state and outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d    = state_q;
        issue_clr  = 1'b0;
        issue_step = 1'b0;
        fill_clr   = 1'b0;
        done       = 1'b0;
        cache_hit  = 1'b0;
        stall      = 1'b1;
        err        = 1'b0;

        // Default is a compare read of the requested word
        cache_cmd.index     = addr_index;
        cache_cmd.word      = addr_word;
        cache_cmd.tag       = addr_tag;
        cache_cmd.wdata     = data_in;
        cache_cmd.write     = 1'b0;
        cache_cmd.comp      = 1'b1;
        cache_cmd.set_valid = 1'b0;

        bank_req.waddr = {addr_tag, addr_index, issue_count};
        bank_req.wdata = cache_rsp.rdata;
        bank_req.wr    = 1'b0;
        bank_req.rd    = 1'b0;

        // Returned words land while reads are still being issued
        if (state_q == FETCH || state_q == FILL) begin
            cache_cmd.comp      = 1'b0;
            cache_cmd.word      = fill_count;
            cache_cmd.wdata     = bank_rsp.rdata;
            cache_cmd.write     = bank_rsp.rd_valid;
            cache_cmd.set_valid = 1'b1;
        end

        case (state_q)
            IDLE: begin
                stall           = 1'b0;
                issue_clr       = 1'b1;
                fill_clr        = 1'b1;
                cache_cmd.write = wr & hit_now;
                done            = hit_now;
                cache_hit       = hit_now;
                if (req) begin
                    if (bad_req) begin
                        state_d = ERR;
                    end else if (!cache_rsp.hit) begin
                        state_d = (cache_rsp.valid && cache_rsp.dirty) ? WB : FETCH;
                    end
                end
            end
            WB: begin
                // Victim word goes back to its own tag's block
                cache_cmd.comp = 1'b0;
                cache_cmd.word = issue_count;
                bank_req.waddr = {cache_rsp.tag, addr_index, issue_count};
                bank_req.wr    = 1'b1;
                issue_step     = 1'b1;
                if (issue_last) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                bank_req.rd = 1'b1;
                issue_step  = 1'b1;
                if (issue_last) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (bank_rsp.rd_valid && fill_last) begin
                    state_d = TOUCH;
                end
            end
            TOUCH: begin
                cache_cmd.write = wr;
                state_d         = DONE;
            end
            DONE: begin
                done    = 1'b1;
                state_d = IDLE;
            end
            ERR: begin
                stall = 1'b0;
                err   = 1'b1;
            end
            default: begin
                state_d = ERR;
            end
        endcase
    end

endmodule

//--- mem_system/mem_system.sv
// Data memory subsystem top level
// Direct-mapped write-back cache in front of a four-bank main memory.
// Requests hold until done; misses stall while the block is moved.
`timescale 1ns/1ps

module mem_system
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] data_in,
    input  logic              rd,
    input  logic              wr,
    output logic [DATA_W-1:0] data_out,
    output logic              done,
    output logic              stall,
    output logic              cache_hit,
    output logic              err
);

    cache_cmd_t        cache_cmd;
    cache_rsp_t        cache_rsp;
    bank_req_t         bank_req;
    bank_rsp_t         bank_rsp;
    logic              issue_clr;
    logic              issue_step;
    logic              fill_clr;
    logic              fill_step;
    logic [WORD_W-1:0] issue_count;
    logic [WORD_W-1:0] fill_count;
    logic              issue_last;
    logic              fill_last;
    logic              ctrl_err;
    logic              bank_err;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .data_in    (data_in),
        .rd         (rd),
        .wr         (wr),
        .cache_cmd  (cache_cmd),
        .cache_rsp  (cache_rsp),
        .bank_req   (bank_req),
        .bank_rsp   (bank_rsp),
        .issue_clr  (issue_clr),
        .issue_step (issue_step),
        .fill_clr   (fill_clr),
        .fill_step  (fill_step),
        .issue_count(issue_count),
        .fill_count (fill_count),
        .issue_last (issue_last),
        .fill_last  (fill_last),
        .data_out   (data_out),
        .done       (done),
        .stall      (stall),
        .cache_hit  (cache_hit),
        .err        (ctrl_err)
    );

    // Memory accesses issued for the current block
    beat_counter issue_cnt (
        .clk  (clk),
        .rst_n(rst_n),
        .clr  (issue_clr),
        .step (issue_step),
        .count(issue_count),
        .last (issue_last)
    );

    // Words returned by memory for the current block
    beat_counter fill_cnt (
        .clk  (clk),
        .rst_n(rst_n),
        .clr  (fill_clr),
        .step (fill_step),
        .count(fill_count),
        .last (fill_last)
    );

    cache_array u_cache (
        .clk  (clk),
        .rst_n(rst_n),
        .cmd  (cache_cmd),
        .rsp  (cache_rsp)
    );

    bank_mem u_mem (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (bank_req),
        .rsp  (bank_rsp),
        .err  (bank_err)
    );

    assign err = ctrl_err | bank_err;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

verilator --binary --timing -f tb.f --top-module tb_mem_system -o tb_sim &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    { echo "build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } ||
    echo "simulation passed"

//--- source/bank_mem.sv
// Four-bank interleaved main memory
// 32K words split over four banks by the low word-address bits. Each
// bank stays busy for a few cycles after an access, and reads return
// through a fixed-latency pipeline so several can be in flight.
// Touching a busy bank sets a sticky error.
`timescale 1ns/1ps

module bank_mem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bank_req_t req,
    output bank_rsp_t rsp,
    output logic      err
);

    localparam int ROW_W  = WADDR_W - WORD_W;
    localparam int BUSY_W = $clog2(BANK_BUSY) + 1;

    logic [DATA_W-1:0] mem_q [BEATS][BANK_ROWS];
    logic [BUSY_W-1:0] busy_q [BEATS];

    logic [MEM_LATENCY-1:0] vld_q;
    logic [DATA_W-1:0]      pipe_q [MEM_LATENCY];

    logic [WORD_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic              access;
    logic              err_q;

    assign bank   = req.waddr[WORD_W-1:0];
    assign row    = req.waddr[WADDR_W-1:WORD_W];
    assign access = req.rd | req.wr;

    // Memory contents start cleared
    initial begin
        for (int b = 0; b < BEATS; b++) begin
            for (int r = 0; r < BANK_ROWS; r++) begin
                mem_q[b][r] = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bank busy timers and error
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < BEATS; b++) begin
                busy_q[b] <= '0;
            end
            err_q <= 1'b0;
        end else begin
            for (int b = 0; b < BEATS; b++) begin
                if (access && bank == WORD_W'(b)) begin
                    busy_q[b] <= BUSY_W'(BANK_BUSY - 1);
                end else if (busy_q[b] != '0) begin
                    busy_q[b] <= busy_q[b] - 1'b1;
                end
            end
            if (access && busy_q[bank] != '0) begin
                err_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage and read pipeline
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req.wr) begin
            mem_q[bank][row] <= req.wdata;
        end
        pipe_q[0] <= mem_q[bank][row];
        for (int s = 1; s < MEM_LATENCY; s++) begin
            pipe_q[s] <= pipe_q[s-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MEM_LATENCY-2:0], req.rd};
        end
    end

    assign rsp.rdata    = pipe_q[MEM_LATENCY-1];
    assign rsp.rd_valid = vld_q[MEM_LATENCY-1];
    assign err          = err_q;

endmodule

//--- tb.f
+incdir+testbench
common/mem_pkg.sv
mem_system/beat_counter.sv
cache/cache_array.sv
source/bank_mem.sv
mem_system/cache_ctrl.sv
mem_system/mem_system.sv
testbench/tb_mem_system.sv

//--- testbench/tb_checks.svh
// Memory subsystem testbench helpers
// Error counters, typed compare tasks, the request driver with its
// done wait, and the wait for the sticky error flag
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int data_errors    = 0;
int flag_errors    = 0;
int timeout_errors = 0;

task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                          input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
        $display("FAIL at %0t: %s expected %h got %h", $time, name, expected, actual);
        data_errors++;
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("FAIL at %0t: %s expected %b got %b", $time, name, expected, actual);
        flag_errors++;
    end
endtask

//////////////////////////////////////////////////////////////////////
// Request driver
//////////////////////////////////////////////////////////////////////
// Holds the request until done, then drops it at the next falling edge
task automatic run_request(input logic is_wr, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] d, output logic got_done,
                           output logic [DATA_W-1:0] rdata, output logic hit,
                           output logic saw_stall);
    int cyc;
    got_done  = 1'b0;
    rdata     = '0;
    hit       = 1'b0;
    saw_stall = 1'b0;
    cyc       = 0;
    @(negedge clk);
    addr    = a;
    data_in = d;
    rd      = ~is_wr;
    wr      = is_wr;
    while (!got_done && cyc < DONE_TIMEOUT) begin
        // Sample in the quiet part of the low phase
        #(CLK_PERIOD / 4);
        if (stall === 1'b1) begin
            saw_stall = 1'b1;
        end
        if (done === 1'b1) begin
            got_done = 1'b1;
            rdata    = data_out;
            hit      = cache_hit;
        end else begin
            @(negedge clk);
            cyc++;
        end
    end
    if (!got_done) begin
        $display("ERROR at %0t: no done within timeout for address %h", $time, a);
        timeout_errors++;
    end
    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
endtask

task automatic wait_for_err();
    int   cyc;
    logic seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < DONE_TIMEOUT) begin
        #(CLK_PERIOD / 4);
        if (err === 1'b1) begin
            seen = 1'b1;
        end else begin
            @(negedge clk);
            cyc++;
        end
    end
    if (!seen) begin
        $display("ERROR at %0t: err did not rise within timeout", $time);
        timeout_errors++;
    end
endtask

`endif

//--- testbench/tb_mem_system.sv
// Memory subsystem testbench
// Directed tests against a shadow memory and a per-line tag model
// that predicts hits, plus a seeded random mix and the error lock.
`timescale 1ns/1ps

module tb_mem_system
    import mem_pkg::*;
;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    localparam int          DONE_TIMEOUT = 50;
    localparam int          HOLD_CYCLES  = 10;
    localparam logic [31:0] SEED         = 32'd95694;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_in;
    logic              rd;
    logic              wr;
    logic [DATA_W-1:0] data_out;
    logic              done;
    logic              stall;
    logic              cache_hit;
    logic              err;

    // Expected word per word address, and the tag held at each line
    logic [DATA_W-1:0] shadow [MEM_WORDS];
    logic              line_valid [NUM_LINES];
    logic [TAG_W-1:0]  line_tag [NUM_LINES];
    logic [31:0]       rng_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_system dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .data_in  (data_in),
        .rd       (rd),
        .wr       (wr),
        .data_out (data_out),
        .done     (done),
        .stall    (stall),
        .cache_hit(cache_hit),
        .err      (err)
    );

    `include "tb_checks.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_word(output logic [DATA_W-1:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state[DATA_W-1:0];
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                     input logic [INDEX_W-1:0] idx,
                                                     input logic [WORD_W-1:0] word);
        return {tag, idx, word, 1'b0};
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // One request checked against the shadow memory and the tag model
    task automatic access(input logic is_wr, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rdata);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic               exp_hit;
        logic               got_done;
        logic               hit;
        logic               saw_stall;
        idx     = a[WORD_W+1 +: INDEX_W];
        tag     = a[ADDR_W-1 -: TAG_W];
        exp_hit = line_valid[idx] && (line_tag[idx] == tag);
        run_request(is_wr, a, d, got_done, rdata, hit, saw_stall);
        if (got_done) begin
            check_flag("cache_hit", exp_hit, hit);
            check_flag("stall", !exp_hit, saw_stall);
            check_flag("err", 1'b0, err);
            if (!is_wr) begin
                check_data("data_out", shadow[a[ADDR_W-1:1]], rdata);
            end
        end
        if (is_wr) begin
            shadow[a[ADDR_W-1:1]] = d;
        end
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tag;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic write_miss_read_hit();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] rdata;
        a = make_addr(5'd1, 8'd10, 2'd1);
        next_word(val);
        access(1'b1, a, val, rdata);
        access(1'b0, a, '0, rdata);
        check_data("data_out", val, rdata);
    endtask

    task automatic whole_block_fill();
        logic [DATA_W-1:0] rdata;
        access(1'b0, make_addr(5'd2, 8'd20, 2'd0), '0, rdata);
        check_data("data_out", '0, rdata);
        for (int w = 1; w < BEATS; w++) begin
            access(1'b0, make_addr(5'd2, 8'd20, w[WORD_W-1:0]), '0, rdata);
        end
    endtask

    task automatic dirty_eviction();
        logic [ADDR_W-1:0] x;
        logic [ADDR_W-1:0] y;
        logic [DATA_W-1:0] val_a;
        logic [DATA_W-1:0] val_b;
        logic [DATA_W-1:0] rdata;
        x = make_addr(5'd1, 8'd40, 2'd2);
        y = make_addr(5'd3, 8'd40, 2'd2);
        next_word(val_a);
        next_word(val_b);
        access(1'b1, x, val_a, rdata);
        access(1'b1, y, val_b, rdata);
        access(1'b0, x, '0, rdata);
        check_data("data_out", val_a, rdata);
        access(1'b0, y, '0, rdata);
        check_data("data_out", val_b, rdata);
    endtask

    task automatic clean_eviction();
        logic [ADDR_W-1:0] p;
        logic [ADDR_W-1:0] q;
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] rdata;
        p = make_addr(5'd4, 8'd60, 2'd1);
        q = make_addr(5'd6, 8'd60, 2'd1);
        next_word(val);
        // Push the written block out to memory, then bounce it clean
        access(1'b1, p, val, rdata);
        access(1'b0, q, '0, rdata);
        access(1'b0, p, '0, rdata);
        access(1'b0, q, '0, rdata);
        access(1'b0, p, '0, rdata);
        check_data("data_out", val, rdata);
    endtask

    task automatic random_mix();
        logic [31:0]       r;
        logic [DATA_W-1:0] rdata;
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            access(r[6], make_addr({3'b001, r[1:0]}, {6'd3, r[3:2]}, r[5:4]),
                   r[31:16], rdata);
        end
    endtask

    task automatic sticky_error();
        logic [DATA_W-1:0] rdata;
        @(negedge clk);
        addr = 16'h0123;
        rd   = 1'b1;
        wr   = 1'b0;
        wait_for_err();
        @(negedge clk);
        rd   = 1'b0;
        addr = 16'h0240;
        @(negedge clk);
        rd = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            check_flag("err", 1'b1, err);
            check_flag("done", 1'b0, done);
        end
        @(negedge clk);
        rd = 1'b0;
        apply_reset();
        check_flag("err", 1'b0, err);
        // Reset drops all lines, so use a block never written
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
        end
        access(1'b0, make_addr(5'd31, 8'd200, 2'd3), '0, rdata);
        check_data("data_out", '0, rdata);
    endtask

    initial begin
        rst_n     = 1'b0;
        addr      = '0;
        data_in   = '0;
        rd        = 1'b0;
        wr        = 1'b0;
        rng_state = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end
        apply_reset();
        write_miss_read_hit();
        whole_block_fill();
        dirty_eviction();
        clean_eviction();
        random_mix();
        sticky_error();
        $display("errors: data %0d, flag %0d, timeout %0d",
                 data_errors, flag_errors, timeout_errors);
        if (data_errors + flag_errors + timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
